//--- common/unpack_settings.svh
// --------------------------------------------------------------------------
// Geometry and width constants for the CPRI receive unpacker
// Include wherever a module or package needs a size or a limit
// --------------------------------------------------------------------------
`ifndef UNPACK_SETTINGS_SVH
`define UNPACK_SETTINGS_SVH

// Stream and sample widths
`define ANT_NUM          4
`define LANE_W           16
`define MANT_W           7
`define IQ_W             16

// Block floating point and AGC
`define EXP_W            4
`define EXP_MAX          9
`define EXP_PER_ANT      8
`define AGC_SHIFT_W      8

// Symbol geometry
`define RE_PER_PRB       12
`define PRB_PER_SYMBOL   132
`define RE_PER_SYMBOL    1584

`endif

//--- common/unpack_pkg.sv
// --------------------------------------------------------------------------
// Shared data types of the receive unpacker, sized from the settings header
// --------------------------------------------------------------------------
`include "unpack_settings.svh"

package unpack_pkg;

    // Input stream word, four 16-bit antenna lanes
    typedef logic [`ANT_NUM*`LANE_W-1:0] cpri_word_t;

    // Compressed sample, I mantissa on top and Q below
    typedef logic [2*`MANT_W-1:0] cmp_sample_t;
    typedef cmp_sample_t [`ANT_NUM-1:0] cmp_group_t;

    // Expanded sample, I in the upper half
    typedef logic [2*`IQ_W-1:0] iq_t;
    typedef iq_t [`ANT_NUM-1:0] iq_group_t;

    // One nibble per antenna and exponent slot
    typedef logic [`ANT_NUM*`EXP_PER_ANT*`EXP_W-1:0] rb_exp_t;

    // One shift byte per antenna
    typedef logic [`ANT_NUM*`AGC_SHIFT_W-1:0] agc_shift_t;

    typedef logic [$clog2(`RE_PER_SYMBOL)-1:0] re_addr_t;

    // Gearbox phase over the 7-word packing period plus flush
    typedef logic [2:0] phase_t;

endpackage

//--- design/unpack_ctrl.sv
// --------------------------------------------------------------------------
// Unpacker control: gearbox phase, input ready and RE/PRB counting
// Slot, address and last are delayed to meet their samples downstream
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "unpack_settings.svh"

module unpack_ctrl import unpack_pkg::*; (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_valid,
    output logic                             o_ready,
    output logic                             o_take,
    output logic                             o_flush,
    output phase_t                           o_phase,
    output logic [$clog2(`EXP_PER_ANT)-1:0] o_slot,
    output re_addr_t                         o_addr,
    output logic                             o_last
);

    phase_t                                 phase;
    logic                                   take_now;
    logic                                   flush_now;
    logic                                   step;
    logic                                   addr_end;
    logic                                   prb_end;
    logic [$clog2(`RE_PER_PRB)-1:0]         re_cnt;
    logic [$clog2(`PRB_PER_SYMBOL)-1:0]     prb_cnt;
    re_addr_t                               addr_cnt;
    logic [1:0][$clog2(`EXP_PER_ANT)-1:0]   slot_d;
    re_addr_t [2:0]                         addr_d;
    logic [2:0]                             last_d;

    // Phase 7 emits the residue, no word is taken then
    assign flush_now = (phase == phase_t'(7));
    assign o_ready   = !flush_now;
    assign take_now  = i_valid && o_ready;
    assign step      = take_now || flush_now;

    assign addr_end  = (addr_cnt == re_addr_t'(`RE_PER_SYMBOL - 1));
    assign prb_end   = (re_cnt == ($clog2(`RE_PER_PRB))'(`RE_PER_PRB - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase   <= '0;
            o_take  <= 1'b0;
            o_flush <= 1'b0;
            o_phase <= '0;
        end else begin
            if (step)
                phase <= phase + phase_t'(1);
            o_take  <= take_now;
            o_flush <= flush_now;
            o_phase <= phase;
        end
    end

    // One RE per take or flush, all counters restart after the last RE
    always_ff @(posedge i_clk) begin
        if (i_reset || (step && addr_end)) begin
            re_cnt   <= '0;
            prb_cnt  <= '0;
            addr_cnt <= '0;
        end else if (step) begin
            addr_cnt <= addr_cnt + re_addr_t'(1);
            if (prb_end) begin
                re_cnt  <= '0;
                prb_cnt <= prb_cnt + 1'b1;
            end else begin
                re_cnt <= re_cnt + 1'b1;
            end
        end
    end

    // Slot feeds the expander two stages on
    always_ff @(posedge i_clk) begin
        slot_d <= {slot_d[0], prb_cnt[$clog2(`EXP_PER_ANT)-1:0]};
    end

    // Address and last ride to the output register three stages on
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            addr_d <= '0;
            last_d <= '0;
        end else begin
            addr_d <= {addr_d[1:0], addr_cnt};
            last_d <= {last_d[1:0], addr_end};
        end
    end

    assign o_slot = slot_d[1];
    assign o_addr = addr_d[2];
    assign o_last = last_d[2];

endmodule

//--- design/iq_gearbox.sv
// --------------------------------------------------------------------------
// 16-to-14 bit gearbox, one residue register per antenna lane
// Driven by the registered take/flush strobes and phase from the control
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "unpack_settings.svh"

module iq_gearbox import unpack_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_take,
    input  logic       i_flush,
    input  phase_t     i_phase,
    input  cpri_word_t i_data,
    output logic       o_vld,
    output cmp_group_t o_samples
);

    cpri_word_t word_q;
    logic [3:0] lead_bits;
    cmp_group_t residue;
    cmp_group_t joined;
    cmp_group_t spill;

    // Word register lines up with the registered take strobe
    always_ff @(posedge i_clk) begin
        word_q <= i_data;
    end

    // Residue holds 2p bits at phase p
    assign lead_bits = {i_phase, 1'b0};

    always_comb begin
        logic [`LANE_W-1:0] lane;
        for (int a = 0; a < `ANT_NUM; a++) begin
            lane     = word_q[a*`LANE_W +: `LANE_W];
            joined[a] = residue[a] | cmp_sample_t'(lane << lead_bits);
            spill[a]  = cmp_sample_t'(lane >> (2*`MANT_W - lead_bits));
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush)
            residue <= '0;
        else if (i_take)
            residue <= spill;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_vld <= 1'b0;
        else
            o_vld <= i_take || i_flush;
        // Flush emits the full 14-bit residue
        if (i_flush)
            o_samples <= residue;
        else if (i_take)
            o_samples <= joined;
    end

endmodule

//--- design/bfp_expander.sv
// --------------------------------------------------------------------------
// Block floating point expansion of 7-bit I/Q mantissas to 16 bits
// Exponent nibble is chosen per antenna by the PRB slot, clipped at the max
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "unpack_settings.svh"

module bfp_expander import unpack_pkg::*; (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_vld,
    input  cmp_group_t                       i_samples,
    input  logic [$clog2(`EXP_PER_ANT)-1:0] i_slot,
    input  rb_exp_t                          i_rb_exp,
    output logic                             o_vld,
    output iq_group_t                        o_iq
);

    logic [`ANT_NUM-1:0][`EXP_W-1:0] exp_sel;

    // Sign-extend then scale up by the exponent
    function automatic logic [`IQ_W-1:0] expand(input logic [`MANT_W-1:0] mant,
                                                 input logic [`EXP_W-1:0]  shift);
        logic [`IQ_W-1:0] ext;
        ext = {{(`IQ_W-`MANT_W){mant[`MANT_W-1]}}, mant};
        return ext << shift;
    endfunction

    always_comb begin
        logic [`EXP_W-1:0] nib;
        for (int a = 0; a < `ANT_NUM; a++) begin
            nib = i_rb_exp[a*`EXP_PER_ANT*`EXP_W + i_slot*`EXP_W +: `EXP_W];
            // Exponents above the limit saturate
            exp_sel[a] = (nib > `EXP_W'(`EXP_MAX)) ? `EXP_W'(`EXP_MAX) : nib;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_vld <= 1'b0;
        else
            o_vld <= i_vld;
        for (int a = 0; a < `ANT_NUM; a++) begin
            o_iq[a] <= {expand(i_samples[a][2*`MANT_W-1:`MANT_W], exp_sel[a]),
                        expand(i_samples[a][`MANT_W-1:0], exp_sel[a])};
        end
    end

endmodule

//--- design/agc_scaler.sv
// --------------------------------------------------------------------------
// Per-antenna FFT AGC arithmetic right shift and the output register stage
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "unpack_settings.svh"

module agc_scaler import unpack_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_vld,
    input  iq_group_t  i_iq,
    input  re_addr_t   i_addr,
    input  logic       i_last,
    input  agc_shift_t i_agc_shift,
    output logic       o_iq_vld,
    output iq_group_t  o_iq_data,
    output re_addr_t   o_iq_addr,
    output logic       o_iq_last
);

    // Large shifts leave only sign bits
    function automatic logic [`IQ_W-1:0] scale(input logic [`IQ_W-1:0]        val,
                                                input logic [`AGC_SHIFT_W-1:0] shift);
        return $signed(val) >>> shift;
    endfunction

    always_ff @(posedge i_clk) begin
        logic [`AGC_SHIFT_W-1:0] sh;
        for (int a = 0; a < `ANT_NUM; a++) begin
            sh = i_agc_shift[a*`AGC_SHIFT_W +: `AGC_SHIFT_W];
            // Data reads as zero between valid REs
            if (i_vld)
                o_iq_data[a] <= {scale(i_iq[a][2*`IQ_W-1:`IQ_W], sh),
                                 scale(i_iq[a][`IQ_W-1:0], sh)};
            else
                o_iq_data[a] <= '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_iq_vld  <= 1'b0;
            o_iq_addr <= '0;
            o_iq_last <= 1'b0;
        end else begin
            o_iq_vld  <= i_vld;
            o_iq_addr <= i_addr;
            o_iq_last <= i_vld && i_last;
        end
    end

endmodule

//--- design/rx_unpack_top.sv
// --------------------------------------------------------------------------
// Receive unpacker top level: 7-to-8 gearbox, BFP expansion and AGC shift
// Accepts a valid/ready word stream, emits one RE per cycle for all antennas
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module rx_unpack_top import unpack_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_valid,
    input  cpri_word_t i_data,
    output logic       o_ready,
    input  rb_exp_t    i_rb_exp,
    input  agc_shift_t i_agc_shift,
    output logic       o_iq_vld,
    output iq_group_t  o_iq_data,
    output re_addr_t   o_iq_addr,
    output logic       o_iq_last
);

    logic       take;
    logic       flush;
    phase_t     phase;
    logic [2:0] slot;
    re_addr_t   addr;
    logic       last;
    logic       gb_vld;
    cmp_group_t gb_samples;
    logic       exp_vld;
    iq_group_t  exp_iq;

    unpack_ctrl u_ctrl (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .o_take  (take),
        .o_flush (flush),
        .o_phase (phase),
        .o_slot  (slot),
        .o_addr  (addr),
        .o_last  (last)
    );

    iq_gearbox u_gearbox (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_take    (take),
        .i_flush   (flush),
        .i_phase   (phase),
        .i_data    (i_data),
        .o_vld     (gb_vld),
        .o_samples (gb_samples)
    );

    bfp_expander u_expander (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_vld     (gb_vld),
        .i_samples (gb_samples),
        .i_slot    (slot),
        .i_rb_exp  (i_rb_exp),
        .o_vld     (exp_vld),
        .o_iq      (exp_iq)
    );

    agc_scaler u_agc (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_vld       (exp_vld),
        .i_iq        (exp_iq),
        .i_addr      (addr),
        .i_last      (last),
        .i_agc_shift (i_agc_shift),
        .o_iq_vld    (o_iq_vld),
        .o_iq_data   (o_iq_data),
        .o_iq_addr   (o_iq_addr),
        .o_iq_last   (o_iq_last)
    );

endmodule

//--- bench/tb_clock_gen.sv
// --------------------------------------------------------------------------
// Testbench clock (20 ns) and synchronous reset held for two cycles
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    localparam int HALF_PERIOD = 10;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Release on a rising edge so the DUT sees a clean synchronous reset
    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

//--- bench/rx_unpack_assertions.sv
// --------------------------------------------------------------------------
// Protocol checks on the unpacker ports, bound into the top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "unpack_settings.svh"

module rx_unpack_assertions import unpack_pkg::*; (
    input logic     i_clk,
    input logic     i_reset,
    input logic     i_valid,
    input logic     i_ready,
    input logic     i_iq_vld,
    input re_addr_t i_iq_addr,
    input logic     i_iq_last
);

    logic        accept;
    logic        word_seen;
    logic [2:0]  take_cnt;
    re_addr_t    next_addr;
    int unsigned fail_count = 0;

    assign accept = i_valid && i_ready;

    // Accepted words modulo 7 and the next expected RE address
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            word_seen <= 1'b0;
            take_cnt  <= '0;
            next_addr <= '0;
        end else begin
            if (accept) begin
                word_seen <= 1'b1;
                take_cnt  <= (take_cnt == 3'd6) ? 3'd0 : take_cnt + 3'd1;
            end
            if (i_iq_vld)
                next_addr <= (next_addr == re_addr_t'(`RE_PER_SYMBOL - 1)) ?
                             '0 : next_addr + re_addr_t'(1);
        end
    end

    a_idle_after_reset: assert property (@(posedge i_clk) disable iff (i_reset)
        !word_seen |-> i_ready && !i_iq_vld && !i_iq_last)
        else begin fail_count++; $error("Outputs not idle before first word"); end

    a_gap_after_seven: assert property (@(posedge i_clk) disable iff (i_reset)
        accept && take_cnt == 3'd6 |=> !i_ready)
        else begin fail_count++; $error("Ready stayed high after seventh word"); end

    a_gap_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_ready |=> i_ready)
        else begin fail_count++; $error("Ready low for more than one cycle"); end

    a_gap_only_there: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_ready |-> $past(accept && take_cnt == 3'd6))
        else begin fail_count++; $error("Ready dropped outside the gearbox gap"); end

    a_addr_order: assert property (@(posedge i_clk) disable iff (i_reset)
        i_iq_vld |-> i_iq_addr == next_addr)
        else begin fail_count++; $error("RE address out of order"); end

    a_last_at_end: assert property (@(posedge i_clk) disable iff (i_reset)
        i_iq_vld |-> i_iq_last == (i_iq_addr == re_addr_t'(`RE_PER_SYMBOL - 1)))
        else begin fail_count++; $error("Last flag not on final RE"); end

    a_last_needs_vld: assert property (@(posedge i_clk) disable iff (i_reset)
        i_iq_last |-> i_iq_vld)
        else begin fail_count++; $error("Last flag without valid"); end

endmodule

//--- bench/rx_unpack_tb.sv
// --------------------------------------------------------------------------
// Testbench for the receive unpacker that packs random samples into the stream
// and compares every output RE with a model of the expansion and AGC shift
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "unpack_settings.svh"

module rx_unpack_tb import unpack_pkg::*; ;

    localparam int SYMBOLS         = 3;
    localparam int SMP_W           = 2 * `MANT_W;
    localparam int GROUP_SAMPLES   = 8;
    localparam int GROUP_WORDS     = 7;
    localparam int PIPE_DEPTH      = 3;
    // A symbol needs well under 4 cycles per RE even with input gaps
    localparam int WATCHDOG_CYCLES = SYMBOLS * `RE_PER_SYMBOL * 4;

    logic       i_clk;
    logic       i_reset;
    logic       i_valid;
    cpri_word_t i_data;
    logic       o_ready;
    rb_exp_t    i_rb_exp;
    agc_shift_t i_agc_shift;
    logic       o_iq_vld;
    iq_group_t  o_iq_data;
    re_addr_t   o_iq_addr;
    logic       o_iq_last;

    integer     seed;
    rb_exp_t    cur_exp;
    agc_shift_t cur_agc;
    iq_group_t  expected_q[$];
    int         sym_outputs;
    int         total_outputs;
    int         symbols_done;

    tb_clock_gen u_clock (.o_clk(i_clk), .o_reset(i_reset));

    rx_unpack_top UUT (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid), .i_data(i_data),
        .o_ready(o_ready), .i_rb_exp(i_rb_exp), .i_agc_shift(i_agc_shift),
        .o_iq_vld(o_iq_vld), .o_iq_data(o_iq_data), .o_iq_addr(o_iq_addr),
        .o_iq_last(o_iq_last)
    );

    bind rx_unpack_top rx_unpack_assertions u_assertions (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid), .i_ready(o_ready),
        .i_iq_vld(o_iq_vld), .i_iq_addr(o_iq_addr), .i_iq_last(o_iq_last)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    // Mantissa times 2^exp, then arithmetic right shift with sign fill
    function automatic logic [`IQ_W-1:0] scale_part(input logic [`MANT_W-1:0] mant,
                                                    input int e, input int sh);
        int v;
        v = int'($signed(mant)) * (1 << e);
        if (sh >= `IQ_W)
            v = (v < 0) ? -1 : 0;
        else
            v = v >>> sh;
        return v[`IQ_W-1:0];
    endfunction

    function automatic iq_t model_re(input cmp_sample_t smp, input int re, input int ant);
        int slot;
        int e;
        int sh;
        slot = (re / `RE_PER_PRB) % `EXP_PER_ANT;
        e    = cur_exp[(ant * `EXP_PER_ANT + slot) * `EXP_W +: `EXP_W];
        if (e > `EXP_MAX)
            e = `EXP_MAX;
        sh   = cur_agc[ant * `AGC_SHIFT_W +: `AGC_SHIFT_W];
        return {scale_part(smp[SMP_W-1:`MANT_W], e, sh), scale_part(smp[`MANT_W-1:0], e, sh)};
    endfunction

    // Starts right after a rising edge and returns on the edge that takes the word
    task automatic drive_word(input cpri_word_t w);
        logic taken;
        taken = 1'b0;
        while (($random(seed) & 3) == 0) begin
            i_valid <= 1'b0;
            @(posedge i_clk);
        end
        i_valid <= 1'b1;
        i_data  <= w;
        while (!taken) begin
            @(negedge i_clk);
            taken = o_ready;
            @(posedge i_clk);
        end
    endtask

    // Eight samples per antenna packed LSB first into seven words
    task automatic send_group(input int first_re);
        logic [GROUP_WORDS*`LANE_W-1:0] stream [`ANT_NUM];
        cpri_word_t  word;
        cmp_sample_t smp;
        iq_group_t   grp;
        for (int k = 0; k < GROUP_SAMPLES; k++) begin
            for (int a = 0; a < `ANT_NUM; a++) begin
                smp = cmp_sample_t'($random(seed));
                stream[a][k*SMP_W +: SMP_W] = smp;
                grp[a] = model_re(smp, first_re + k, a);
            end
            expected_q.push_back(grp);
        end
        for (int w = 0; w < GROUP_WORDS; w++) begin
            for (int a = 0; a < `ANT_NUM; a++)
                word[a*`LANE_W +: `LANE_W] = stream[a][w*`LANE_W +: `LANE_W];
            drive_word(word);
        end
    endtask

    // ----------------------------------------------------------------------
    // Output checking against the model queue
    // ----------------------------------------------------------------------
    always @(negedge i_clk) begin
        iq_group_t want;
        int        bad_ant;
        if (UUT.u_assertions.fail_count != 0) begin
            abort_run("A protocol assertion failed");
        end else if (!i_reset && o_iq_vld) begin
            if (expected_q.size() == 0) begin
                abort_run("Output RE arrived with no expected RE queued");
            end else begin
                want    = expected_q.pop_front();
                bad_ant = -1;
                for (int a = `ANT_NUM - 1; a >= 0; a--)
                    if (o_iq_data[a] !== want[a])
                        bad_ant = a;
                if (bad_ant >= 0) begin
                    $display("** Error at %0t ns: antenna %0d RE %0d data %h, expected %h",
                             $time, bad_ant, sym_outputs, o_iq_data[bad_ant], want[bad_ant]);
                    abort_run("Output data mismatch");
                end else begin
                    total_outputs++;
                    sym_outputs++;
                    if (o_iq_last) begin
                        if (sym_outputs != `RE_PER_SYMBOL) begin
                            abort_run("Symbol ended with the wrong number of REs");
                        end else begin
                            sym_outputs = 0;
                            symbols_done++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        abort_run("Watchdog expired before all REs came out");
    end

    // ----------------------------------------------------------------------
    // Main stimulus
    // ----------------------------------------------------------------------
    initial begin
        i_valid       = 1'b0;
        i_data        = '0;
        i_rb_exp      = '0;
        i_agc_shift   = '0;
        seed          = 32'ha325_5990;
        sym_outputs   = 0;
        total_outputs = 0;
        symbols_done  = 0;
        @(posedge i_clk);
        while (i_reset)
            @(posedge i_clk);

        for (int sym = 0; sym < SYMBOLS; sym++) begin
            // New exponents and AGC shifts only while the pipeline is empty
            cur_exp = {$random(seed), $random(seed), $random(seed), $random(seed)};
            for (int a = 0; a < `ANT_NUM; a++)
                cur_agc[a*`AGC_SHIFT_W +: `AGC_SHIFT_W] = `AGC_SHIFT_W'($random(seed) & 'hf);
            cur_agc[sym*`AGC_SHIFT_W +: `AGC_SHIFT_W] =
                `AGC_SHIFT_W'(16 + ($random(seed) & 'h7f));
            i_rb_exp    <= cur_exp;
            i_agc_shift <= cur_agc;
            @(posedge i_clk);
            for (int g = 0; g < `RE_PER_SYMBOL / GROUP_SAMPLES; g++)
                send_group(g * GROUP_SAMPLES);
            i_valid <= 1'b0;
            while (expected_q.size() != 0)
                @(posedge i_clk);
        end

        // Let any extra output leave the pipeline before the verdict
        repeat (PIPE_DEPTH + 1) @(posedge i_clk);
        if (total_outputs == SYMBOLS * `RE_PER_SYMBOL && symbols_done == SYMBOLS) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Output count does not match the number of REs sent");
        end
    end

endmodule

//--- tb.f
+incdir+common
common/unpack_pkg.sv
design/unpack_ctrl.sv
design/iq_gearbox.sv
design/bfp_expander.sv
design/agc_scaler.sv
design/rx_unpack_top.sv
bench/tb_clock_gen.sv
bench/rx_unpack_assertions.sv
bench/rx_unpack_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the receive unpacker testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module rx_unpack_tb -f tb.f -o rx_unpack_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rx_unpack_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
